// ==== common/ptwPkg.sv ====
//////////////////////////////
// shared types for the Sv32 page table walker
// widths are fixed by Sv32, there is no satp mode field
// physical addresses are 34 bits, PTEs are 32 bits
//////////////////////////////

package ptwPkg;

   //////////////////////////////
   // widths
   //////////////////////////////
   localparam int vaWidth  = 32;   // Sv32 virtual address
   localparam int paWidth  = 34;   // Sv32 physical address
   localparam int ppnWidth = 22;   // physical page number
   localparam int pteWidth = 32;   // one page table entry

   typedef logic [vaWidth-1:0]  vAddr;
   typedef logic [paWidth-1:0]  pAddr;
   typedef logic [ppnWidth-1:0] ppnT;
   typedef logic [pteWidth-1:0] pteWord;

   //////////////////////////////
   // PTE bit positions
   //////////////////////////////
   localparam int pteV = 0;        // valid
   localparam int pteR = 1;        // readable
   localparam int pteW = 2;        // writable
   localparam int pteX = 3;        // executable
   localparam int pteU = 4;        // user page
   localparam int pteG = 5;        // global mapping
   localparam int pteA = 6;        // accessed
   localparam int pteD = 7;        // dirty
   localparam int ppnHi  = 31;     // full PPN field
   localparam int ppnLo  = 10;
   localparam int ppn0Hi = 19;     // PPN0, must be zero in a megapage leaf
   localparam int ppn0Lo = 10;

   //////////////////////////////
   // enums
   //////////////////////////////
   typedef enum logic {kiloPage, megaPage} pageKind;

   typedef enum logic [1:0] {instrPage, loadPage, storePage, accessErr} faultKind;

   // walker FSM, kept here so waveforms decode the state by name
   typedef enum logic [2:0] {
      idle, l1Read, l1Check, l0Read, l0Check, leafOut, faultOut
   } walkState;

   //////////////////////////////
   // structs
   //////////////////////////////
   typedef struct packed {
      vAddr va;                    // address that missed
      logic isData;                // 1 = data TLB, 0 = instruction TLB
      logic isStore;               // only meaningful with isData
   } walkReq;

   typedef struct packed {
      pteWord  pte;                // leaf entry as read from memory
      pageKind kind;
      logic    toData;             // steers the write to the data TLB
   } walkResult;

   typedef struct packed {
      pAddr addr;
      logic valid;                 // single cycle request strobe
   } apbRead;

   typedef struct packed {
      logic valid;                 // V set and not W without R
      logic leaf;                  // any of R, W, X
      logic misaligned;            // megapage with nonzero PPN0
      logic adFault;               // A clear, or store with D clear
   } pteFlags;

endpackage

// ==== src/walker/pteCheck.sv ====
//////////////////////////////
// combinational decode of one Sv32 PTE
// no privilege checks, U and SUM are not looked at
//////////////////////////////

`timescale 1ns/10ps

module pteCheck (
   input  ptwPkg::pteWord  pte,
   input  logic            firstLevel,   // entry came from the level 1 table
   input  logic            isStore,
   output ptwPkg::pteFlags flags
);

   logic permR, permW, permX;      // unswizzled permission bits
   logic bitA, bitD;
   logic ppn0Set;

   assign permR = pte[ptwPkg::pteR];
   assign permW = pte[ptwPkg::pteW];
   assign permX = pte[ptwPkg::pteX];
   assign bitA  = pte[ptwPkg::pteA];
   assign bitD  = pte[ptwPkg::pteD];

   // a megapage has to start on a 4 MiB boundary
   assign ppn0Set = |pte[ptwPkg::ppn0Hi:ptwPkg::ppn0Lo];

   always_comb begin
      // W without R is reserved, treat it as not valid
      flags.valid      = pte[ptwPkg::pteV] & ~(permW & ~permR);
      flags.leaf       = permR | permW | permX;       // pointer entries have RWX = 0
      flags.misaligned = firstLevel & ppn0Set;
      // no hardware A/D update, so a missing bit is a fault
      flags.adFault    = ~bitA | (isStore & ~bitD);
   end

endmodule

// ==== src/walker/pageWalker.sv ====
//////////////////////////////
// Sv32 walk FSM over at most two levels
// A and D are never written back so a missing bit faults
// one walk in flight and one read outstanding
// rdErr at any level gives accessErr
//////////////////////////////

`timescale 1ns/10ps

module pageWalker (
   input  logic              clk,
   input  logic              arstN,
   input  ptwPkg::ppnT       rootPpn,
   input  logic              reqValid,
   input  ptwPkg::walkReq    req,
   output logic              walkDone,
   output ptwPkg::apbRead    rd,
   input  logic              rdDone,
   input  ptwPkg::pteWord    rdData,
   input  logic              rdErr,
   output logic              tlbWrite,
   output ptwPkg::walkResult result,
   output logic              pageFault,
   output ptwPkg::faultKind  fault,
   output logic              busy
);

   ptwPkg::walkState state, stateNext;
   ptwPkg::pteWord   pteQ;         // last fetched entry
   ptwPkg::pageKind  kindQ;
   ptwPkg::faultKind faultQ;
   ptwPkg::faultKind reqFault;     // page fault kind for this request
   ptwPkg::pteFlags  flags;
   ptwPkg::pAddr     l1Addr, l0Addr;
   logic             issuedQ;      // read of the current state already sent
   logic             readState;
   logic             l1Leaf, l1Descend, l0Leaf;

   assign readState  = (state == ptwPkg::l1Read) || (state == ptwPkg::l0Read);

   //////////////////////////////
   // PTE check
   //////////////////////////////
   pteCheck pteCheck_inst (
      .pte        (pteQ),
      .firstLevel (state == ptwPkg::l1Check),
      .isStore    (req.isStore),
      .flags      (flags)
   );

   assign l1Leaf    = flags.valid & flags.leaf & ~flags.misaligned & ~flags.adFault;
   assign l1Descend = flags.valid & ~flags.leaf;          // pointer to level 0
   assign l0Leaf    = flags.valid & flags.leaf & ~flags.adFault;

   always_comb begin
      if (!req.isData)      reqFault = ptwPkg::instrPage;
      else if (req.isStore) reqFault = ptwPkg::storePage;
      else                  reqFault = ptwPkg::loadPage;
   end

   //////////////////////////////
   // state machine
   //////////////////////////////
   always_comb begin
      stateNext = state;
      case (state)
         ptwPkg::idle: if (reqValid) stateNext = ptwPkg::l1Read;
         ptwPkg::l1Read, ptwPkg::l0Read: begin
            if (rdDone) begin
               if (rdErr)                          stateNext = ptwPkg::faultOut;
               else if (state == ptwPkg::l1Read)   stateNext = ptwPkg::l1Check;
               else                                stateNext = ptwPkg::l0Check;
            end
         end
         ptwPkg::l1Check: begin
            if (l1Leaf)         stateNext = ptwPkg::leafOut;     // megapage
            else if (l1Descend) stateNext = ptwPkg::l0Read;
            else                stateNext = ptwPkg::faultOut;
         end
         ptwPkg::l0Check: stateNext = l0Leaf ? ptwPkg::leafOut : ptwPkg::faultOut;
         ptwPkg::leafOut, ptwPkg::faultOut: stateNext = ptwPkg::idle;
         default: stateNext = ptwPkg::idle;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state   <= ptwPkg::idle;
         issuedQ <= 1'b0;
      end else begin
         state <= stateNext;
         if (rdDone)        issuedQ <= 1'b0;
         else if (rd.valid) issuedQ <= 1'b1;
      end
   end

   // entry, page size and fault kind load only on their events
   always_ff @(posedge clk) begin
      if (readState && rdDone) pteQ <= rdData;
      if (stateNext == ptwPkg::leafOut)
         kindQ <= (state == ptwPkg::l1Check) ? ptwPkg::megaPage : ptwPkg::kiloPage;
      if (stateNext == ptwPkg::faultOut)
         faultQ <= readState ? ptwPkg::accessErr : reqFault;   // bus error wins
   end

   //////////////////////////////
   // read address and outputs
   //////////////////////////////
   assign l1Addr = {rootPpn, req.va[31:22], 2'b00};                        // VPN1
   assign l0Addr = {pteQ[ptwPkg::ppnHi:ptwPkg::ppnLo], req.va[21:12], 2'b00}; // VPN0

   always_comb begin
      rd.valid = readState & ~issuedQ;    // first cycle of a read state
      rd.addr  = (state == ptwPkg::l1Read) ? l1Addr : l0Addr;
   end

   always_comb begin
      result.pte    = pteQ;
      result.kind   = kindQ;
      result.toData = req.isData;
   end

   assign tlbWrite  = (state == ptwPkg::leafOut);
   assign pageFault = (state == ptwPkg::faultOut);
   assign fault     = faultQ;
   assign walkDone  = tlbWrite | pageFault;
   assign busy      = (state != ptwPkg::idle);

   // each read request is a single cycle strobe
   a_rdPulse: assert property (@(posedge clk) disable iff (!arstN)
      rd.valid |=> !rd.valid);
   // an answer only goes out for a request the selector still holds
   a_answerHeld: assert property (@(posedge clk) disable iff (!arstN)
      walkDone |-> reqValid);
   // read data only comes back for a read that was sent
   a_doneIssued: assert property (@(posedge clk) disable iff (!arstN)
      rdDone |-> (readState && issuedQ));

endmodule

// ==== src/missSelect.sv ====
//////////////////////////////
// picks one TLB miss and holds it for the walk
// misses are level signals held until the answer pulse
// data misses win over instruction misses
//////////////////////////////

`timescale 1ns/10ps

module missSelect (
   input  logic           clk,
   input  logic           arstN,
   input  logic           iMiss,
   input  ptwPkg::vAddr   iVa,
   input  logic           dMiss,
   input  ptwPkg::vAddr   dVa,
   input  logic           dStore,
   input  logic           walkDone,   // answer pulse from the walker
   output logic           reqValid,
   output ptwPkg::walkReq req
);

   logic           pending;           // a captured request is being walked
   logic           capture;
   ptwPkg::walkReq reqQ;

   // sample only while nothing is held and not in the walkDone cycle
   assign capture = ~pending & ~walkDone & (iMiss | dMiss);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pending <= 1'b0;
      end else if (walkDone) begin
         pending <= 1'b0;             // requester drops its miss next
      end else if (capture) begin
         pending <= 1'b1;
      end
   end

   // payload loads only on capture
   always_ff @(posedge clk) begin
      if (capture) begin
         reqQ.va      <= dMiss ? dVa : iVa;    // data priority
         reqQ.isData  <= dMiss;
         reqQ.isStore <= dMiss & dStore;
      end
   end

   assign reqValid = pending;
   assign req      = reqQ;

   // requester keeps its miss up until the answer pulse
   a_missHeld: assert property (@(posedge clk) disable iff (!arstN)
      (reqValid && !walkDone) |-> (req.isData ? dMiss : iMiss));

endmodule

// ==== src/apbReadMaster.sv ====
//////////////////////////////
// APB requester, read only
// one read at a time and requests are dropped while busy
// read data and error come back one cycle after pready
//////////////////////////////

`timescale 1ns/10ps

module apbReadMaster (
   input  logic           clk,
   input  logic           arstN,
   input  ptwPkg::apbRead rd,
   output logic           rdDone,
   output ptwPkg::pteWord rdData,
   output logic           rdErr,
   output ptwPkg::pAddr   paddr,
   output logic           psel,
   output logic           penable,
   output logic           pwrite,
   input  ptwPkg::pteWord prdata,
   input  logic           pready,
   input  logic           pslverr
);

   typedef enum logic [1:0] {phIdle, phSetup, phAccess} apbPhase;

   apbPhase phase;
   logic    accept;            // request taken this cycle
   logic    finish;            // access phase completes this cycle

   assign accept = rd.valid & (phase == phIdle);
   assign finish = (phase == phAccess) & pready;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         phase  <= phIdle;
         rdDone <= 1'b0;
      end else begin
         rdDone <= finish;                          // single cycle pulse
         case (phase)
            phIdle:   if (accept) phase <= phSetup;
            phSetup:  phase <= phAccess;            // setup is always 1 cycle
            phAccess: if (pready) phase <= phIdle;  // wait states hold here
            default:  phase <= phIdle;
         endcase
      end
   end

   // address held from request to end of access
   always_ff @(posedge clk) begin
      if (accept) paddr <= rd.addr;
      if (finish) begin
         rdData <= prdata;
         rdErr  <= pslverr;     // pslverr only counts with pready
      end
   end

   assign psel    = (phase != phIdle);
   assign penable = (phase == phAccess);
   assign pwrite  = 1'b0;       // walker never writes PTEs

   // the walker sends no read while one is outstanding
   a_noOverlap: assert property (@(posedge clk) disable iff (!arstN)
      rd.valid |-> (phase == phIdle));

endmodule

// ==== src/ptwTop.sv ====
//////////////////////////////
// Sv32 page table walker top level
// TLB side uses level-held misses, memory side is APB
//////////////////////////////

`timescale 1ns/10ps

module ptwTop (
   input  logic              clk,
   input  logic              arstN,
   input  ptwPkg::ppnT       rootPpn,      // satp.PPN only
   // TLB side
   input  logic              iMiss,
   input  ptwPkg::vAddr      iVa,
   input  logic              dMiss,
   input  ptwPkg::vAddr      dVa,
   input  logic              dStore,
   output logic              tlbWrite,
   output ptwPkg::walkResult result,
   output logic              pageFault,
   output ptwPkg::faultKind  fault,
   output logic              busy,
   // APB requester
   output ptwPkg::pAddr      paddr,
   output logic              psel,
   output logic              penable,
   output logic              pwrite,
   input  ptwPkg::pteWord    prdata,
   input  logic              pready,
   input  logic              pslverr
);

   logic           reqValid;
   ptwPkg::walkReq req;
   logic           walkDone;
   ptwPkg::apbRead rd;
   logic           rdDone;
   ptwPkg::pteWord rdData;
   logic           rdErr;

   missSelect missSelect_inst (
      .clk      (clk),
      .arstN    (arstN),
      .iMiss    (iMiss),
      .iVa      (iVa),
      .dMiss    (dMiss),
      .dVa      (dVa),
      .dStore   (dStore),
      .walkDone (walkDone),
      .reqValid (reqValid),
      .req      (req)
   );

   pageWalker pageWalker_inst (
      .clk       (clk),
      .arstN     (arstN),
      .rootPpn   (rootPpn),
      .reqValid  (reqValid),
      .req       (req),
      .walkDone  (walkDone),
      .rd        (rd),
      .rdDone    (rdDone),
      .rdData    (rdData),
      .rdErr     (rdErr),
      .tlbWrite  (tlbWrite),
      .result    (result),
      .pageFault (pageFault),
      .fault     (fault),
      .busy      (busy)
   );

   apbReadMaster apbReadMaster_inst (
      .clk     (clk),
      .arstN   (arstN),
      .rd      (rd),
      .rdDone  (rdDone),
      .rdData  (rdData),
      .rdErr   (rdErr),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

endmodule

// ==== verification/ptwTb.sv ====
//////////////////////////////
// testbench for the Sv32 page table walker
// PTE memory, misses and expected answers come from walkTrace.txt
// APB completer adds 0 to 3 wait states from an LFSR
// run from the project root so the trace path resolves
//////////////////////////////

`timescale 1ns/10ps

module ptwTb;

   localparam int answerTimeout = 200;      // cycles allowed per walk answer

   logic              clk = 1'b0;
   logic              arstN;
   ptwPkg::ppnT       rootPpn;
   logic              iMiss, dMiss, dStore;
   ptwPkg::vAddr      iVa, dVa;
   logic              tlbWrite, pageFault, busy;
   ptwPkg::walkResult result;
   ptwPkg::faultKind  fault;
   ptwPkg::pAddr      paddr;
   logic              psel, penable, pwrite;
   ptwPkg::pteWord    prdata  = '0;
   logic              pready  = 1'b0;
   logic              pslverr = 1'b0;

   // trace memory with one entry per M line
   ptwPkg::pAddr      memAddr[$];
   ptwPkg::pteWord    memData[$];
   logic              memErr[$];

   // test being assembled from the trace
   string             tName;
   ptwPkg::ppnT       tRoot;
   logic              tIMiss, tDMiss, tDStore;
   ptwPkg::vAddr      tIVa, tDVa;
   bit                expIsFault[$];
   ptwPkg::walkResult expRes[$];
   ptwPkg::faultKind  expFlt[$];

   int                errors = 0;
   int                apbErrors = 0;       // counted by the APB model
   int                tests = 0;
   int                passed = 0;
   bit                timedOut = 1'b0;
   int                readCount = 0;       // APB reads since time 0
   int                walkFirst = 0;       // readCount when the walk began
   int                readBase = 0;
   ptwPkg::pteWord    lastPte = '0;
   logic [15:0]       lfsr = 16'd48374;
   logic [1:0]        waitLeft = 2'd0;

   ptwTop ptwTop_inst (.*);

   always #50 clk = ~clk;                  // 100 ns period

   //////////////////////////////
   // helpers
   //////////////////////////////
   // Galois form of x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic takeBit();
      logic b;
      b = lfsr[0];
      lfsr = lfsrNext(lfsr);               // one step per bit used
      return b;
   endfunction

   function automatic bit memLookup(input ptwPkg::pAddr a, output ptwPkg::pteWord d,
                                    output logic e);
      d = '0;
      e = 1'b0;
      foreach (memAddr[i]) begin
         if (memAddr[i] == a) begin
            d = memData[i];
            e = memErr[i];
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   function automatic ptwPkg::faultKind faultFromName(input string s);
      if (s == "instr") return ptwPkg::instrPage;
      if (s == "store") return ptwPkg::storePage;
      if (s == "access") return ptwPkg::accessErr;
      return ptwPkg::loadPage;
   endfunction

   task automatic checkAddr(input ptwPkg::pAddr got, input ptwPkg::pAddr exp);
      if (got !== exp) begin
         $display("ERR %0t paddr: expected %h, got %h", $time, exp, got);
         apbErrors++;
      end
   endtask

   task automatic checkResult(input ptwPkg::walkResult got, input ptwPkg::walkResult exp);
      ptwPkg::pageKind gotKind;
      ptwPkg::pageKind expKind;
      string           gotText;
      string           expText;
      gotKind = got.kind;
      expKind = exp.kind;
      if (got !== exp) begin
         expText = $sformatf("pte=%h kind=%s toData=%0b", exp.pte, expKind.name(),
                             exp.toData);
         gotText = $sformatf("pte=%h kind=%s toData=%0b", got.pte, gotKind.name(),
                             got.toData);
         $display("ERR %0t result: expected %s, got %s", $time, expText, gotText);
         errors++;
      end
   endtask

   task automatic checkFault(input ptwPkg::faultKind got, input ptwPkg::faultKind exp);
      if (got !== exp) begin
         $display("ERR %0t fault: expected %s, got %s", $time, exp.name(), got.name());
         errors++;
      end
   endtask

   //////////////////////////////
   // APB completer model
   //////////////////////////////
   always @(negedge clk) begin : apbModel
      ptwPkg::vAddr   va;
      ptwPkg::pAddr   expAddr;
      ptwPkg::pteWord d;
      logic           e;
      va = dMiss ? dVa : iVa;              // data miss is walked first
      if (tlbWrite || pageFault) walkFirst = readCount;
      if (!arstN) begin
         pready  = 1'b0;
         pslverr = 1'b0;
      end else if (psel && !penable) begin // setup phase
         if (readCount == walkFirst)
            expAddr = ptwPkg::pAddr'(rootPpn) * 34'd4096 + ptwPkg::pAddr'(va[31:22]) * 34'd4;
         else
            expAddr = ptwPkg::pAddr'(lastPte[31:10]) * 34'd4096
                      + ptwPkg::pAddr'(va[21:12]) * 34'd4;
         checkAddr(paddr, expAddr);
         if (pwrite) begin
            $display("APB write seen at %0t, the walker must only read", $time);
            apbErrors++;
         end
         readCount++;
         waitLeft[1] = takeBit();
         waitLeft[0] = takeBit();
      end else if (psel && penable && !pready) begin
         if (waitLeft == 2'd0) begin
            if (!memLookup(paddr, d, e)) begin
               $display("APB read from %h, an address the trace does not hold", paddr);
               apbErrors++;
            end
            prdata  = d;
            pslverr = e;                   // error addresses answer pslverr
            lastPte = d;
            pready  = 1'b1;
         end else begin
            waitLeft = waitLeft - 2'd1;
         end
      end else begin
         pready  = 1'b0;
         pslverr = 1'b0;
      end
   end

   //////////////////////////////
   // test sequencing
   //////////////////////////////
   task automatic waitAnswer(output bit seen);
      int cycles;
      seen = 1'b0;
      cycles = 0;
      while (!seen && cycles < answerTimeout) begin
         @(negedge clk);
         seen = tlbWrite || pageFault;
         cycles++;
      end
      if (!seen) begin
         $display("test %s: no tlbWrite or pageFault within %0d cycles", tName, answerTimeout);
         errors++;
         timedOut = 1'b1;
      end
   endtask

   task automatic runTest();
      int errStart;
      int expReads;
      int k;
      bit seen;
      errStart = errors + apbErrors;
      @(negedge clk);
      rootPpn = tRoot;
      readBase = readCount;
      iVa = tIVa;
      dVa = tDVa;
      dStore = tDStore;
      iMiss = tIMiss;                      // both may rise together
      dMiss = tDMiss;
      for (k = 0; k < expIsFault.size(); k++) begin
         waitAnswer(seen);
         if (!seen) break;
         if (expIsFault[k]) begin
            if (!pageFault) begin
               $display("test %s: tlbWrite where a page fault was expected", tName);
               errors++;
            end else begin
               checkFault(fault, expFlt[k]);
            end
         end else if (!tlbWrite) begin
            $display("test %s: page fault where a TLB write was expected", tName);
            errors++;
         end else begin
            checkResult(result, expRes[k]);
            expReads = (expRes[k].kind == ptwPkg::megaPage) ? 1 : 2;
            if (readCount - readBase != expReads) begin
               $display("test %s: %0d APB reads for a walk that needs %0d", tName,
                        readCount - readBase, expReads);
               errors++;
            end
         end
         // the answered miss is data while dMiss is still up
         if (dMiss) begin
            dMiss = 1'b0;
            dStore = 1'b0;
         end else begin
            iMiss = 1'b0;
         end
         readBase = readCount;
      end
      tests++;
      if (errors + apbErrors == errStart) begin
         passed++;
         $display("test %s: ok", tName);
      end else begin
         $display("test %s: failed", tName);
      end
   endtask

   initial begin
      int                fd, n, st, td, e;
      bit                haveTest;
      string             line, tag, side, word;
      ptwPkg::pAddr      a;
      ptwPkg::pteWord    d;
      ptwPkg::vAddr      va;
      ptwPkg::walkResult r;
      arstN = 1'b0;
      rootPpn = '0;
      iMiss = 1'b0;
      iVa = '0;
      dMiss = 1'b0;
      dVa = '0;
      dStore = 1'b0;
      haveTest = 1'b0;
      repeat (16) @(negedge clk);
      arstN = 1'b1;
      @(negedge clk);
      if (psel || penable || tlbWrite || pageFault || busy) begin
         $display("outputs are not idle after reset");
         errors++;
      end
      fd = $fopen("verification/walkTrace.txt", "r");
      if (fd == 0) begin
         $display("cannot open verification/walkTrace.txt");
         errors++;
      end else begin
         while (!$feof(fd) && !timedOut) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%s", tag);
            if (n == 1 && tag == "M") begin
               n = $sscanf(line, "%s %h %h %d", tag, a, d, e);
               memAddr.push_back(a);
               memData.push_back(d);
               memErr.push_back(e != 0);
            end else if (n == 1 && tag == "T") begin
               if (haveTest) runTest();    // previous test is complete
               n = $sscanf(line, "%s %s %h", tag, tName, tRoot);
               tIMiss = 1'b0;
               tDMiss = 1'b0;
               tDStore = 1'b0;
               tIVa = '0;
               tDVa = '0;
               expIsFault.delete();
               expRes.delete();
               expFlt.delete();
               haveTest = 1'b1;
            end else if (n == 1 && tag == "R") begin
               n = $sscanf(line, "%s %s %h %d", tag, side, va, st);
               if (side == "D") begin
                  tDMiss = 1'b1;
                  tDVa = va;
                  tDStore = (st != 0);
               end else begin
                  tIMiss = 1'b1;
                  tIVa = va;
               end
            end else if (n == 1 && tag == "X") begin
               n = $sscanf(line, "%s %h %s %d", tag, d, word, td);
               r.pte = d;
               r.kind = (word == "mega") ? ptwPkg::megaPage : ptwPkg::kiloPage;
               r.toData = (td != 0);
               expRes.push_back(r);
               expFlt.push_back(ptwPkg::instrPage);
               expIsFault.push_back(1'b0);
            end else if (n == 1 && tag == "F") begin
               n = $sscanf(line, "%s %s", tag, word);
               r = '0;
               expRes.push_back(r);
               expFlt.push_back(faultFromName(word));
               expIsFault.push_back(1'b1);
            end
         end
         $fclose(fd);
         if (haveTest && !timedOut) runTest();
      end
      $display("tests %0d, passed %0d, failed %0d, errors %0d", tests, passed,
               tests - passed, errors + apbErrors);
      if (errors + apbErrors == 0 && tests > 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== verification/walkTrace.txt ====
# M paddr pte err(1 = pslverr) | T name rootPpn | R side(I/D) va store
# X pte kind(kilo/mega) toData | F fault(instr/load/store/access), in answer order
T megaLoad 00080
M 00080004 001000C7 0
R D 00400123 0
X 001000C7 mega 1
T kiloInstr 00081
M 00081008 00024001 0
M 00090004 048D144B 0
R I 00801ABC 0
X 048D144B kilo 0
T invalidInstr 00082
M 0008200C 00000000 0
R I 00C00000 0
F instr
T storeNoDirty 00083
M 00083010 00200047 0
R D 01000040 1
F store
T wNoRLoad 00084
M 00084014 00000045 0
R D 01400000 0
F load
T nonLeafL0 00085
M 00085018 00024401 0
M 00091008 00024801 0
R D 01802000 0
F load
T misalignedMega 00086
M 0008601C 00100443 0
R D 01C00000 0
F load
T busErrL0 00087
M 00087020 00024801 0
M 0009200C 00000000 1
R D 02003000 0
F access
T dualMiss 00088
M 00088024 003000C7 0
M 00088028 0040004B 0
R D 02400000 0
R I 02800000 0
X 003000C7 mega 1
X 0040004B mega 0

// ==== project.f ====
common/ptwPkg.sv
src/walker/pteCheck.sv
src/walker/pageWalker.sv
src/missSelect.sv
src/apbReadMaster.sv
src/ptwTop.sv
verification/ptwTb.sv

// ==== Makefile ====
# Verilator build for the Sv32 page table walker
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= ptwTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the trace path is relative to the project root, so run from here
run: compile verification/walkTrace.txt
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
